/* Makefile */
VERILATOR ?= verilator
TOP ?= tb_pdp
FILELIST ?= pdp.f
BUILD_DIR ?= obj_dir
LOG ?= sim.log
VFLAGS ?= --binary --timing --assert -Wno-fatal
RUN_ARGS ?= +verilator+error+limit+100
PASS_MSG ?= *** TEST PASSED ***

.PHONY: sim clean

sim:
	$(VERILATOR) $(VFLAGS) --top-module $(TOP) -f $(FILELIST) --Mdir $(BUILD_DIR)
	./$(BUILD_DIR)/V$(TOP) $(RUN_ARGS) | tee $(LOG)
	grep -qF '$(PASS_MSG)' $(LOG)

clean:
	rm -rf $(BUILD_DIR) $(LOG)

/* pdp.f */
pdp_pkg.sv
pdp_control.sv
pdp_memory.sv
pdp_regfile.sv
pdp_decode.sv
pdp_alu.sv
pdp_core.sv
pdp_sva.sv
tb_pdp.sv

/* pdp_alu.sv */
module pdp_alu
	import pdp_pkg::*;
(
	input logic clock,
	input logic reset,
	input logic exec_en,
	input inst_class_t inst_class,
	input logic [op_width-1:0] opcode_sel,
	input logic [word_width-1:0] src_op,
	input logic [word_width-1:0] dst_op,
	input psw_t psw_in,
	output logic [word_width-1:0] result,
	output psw_t new_psw,
	output logic wr_en,
	output logic branch_taken
);

	logic [word_width-1:0] res;
	psw_t flags;
	logic write, low_byte;

	// returns {v, c, sum}; with borrow set, c reads as a borrow out
	function automatic logic [word_width+1:0] add_vc(
		input logic [word_width-1:0] a,
		input logic [word_width-1:0] b,
		input logic cin,
		input logic borrow
	);
		logic [word_width:0] sum;
		sum = {1'b0, a} + {1'b0, b} + cin;
		return {(a[word_width-1] == b[word_width-1]) && (sum[word_width-1] != a[word_width-1]),
			sum[word_width] ^ borrow, sum[word_width-1:0]};
	endfunction

	always_comb
	begin
		res = dst_op;
		flags = psw_in;
		write = 1'b0;
		low_byte = (inst_class == single_operand) && (opcode_sel == op_swab);
		if (inst_class == single_operand)
		begin
			write = (opcode_sel != op_tst);
			flags.v = 1'b0;
			flags.c = 1'b0;
			case (opcode_sel)
				op_clr: res = '0;
				op_com: {flags.c, res} = {1'b1, ~dst_op};
				op_inc: {flags.v, flags.c, res} = {dst_op == 16'o077777, psw_in.c, dst_op + 16'd1};
				op_dec: {flags.v, flags.c, res} = {dst_op == 16'o100000, psw_in.c, dst_op - 16'd1};
				op_neg: {flags.v, flags.c, res} = {dst_op == 16'o100000, dst_op != 16'd0, -dst_op};
				op_adc: {flags.v, flags.c, res} = add_vc(dst_op, '0, psw_in.c, 1'b0);
				op_sbc: {flags.v, flags.c, res} = add_vc(dst_op, '1, ~psw_in.c, 1'b1);
				op_asl: {flags.c, res} = {dst_op, 1'b0};
				op_asr: {res, flags.c} = {dst_op[word_width-1], dst_op};
				op_rol: {flags.c, res} = {dst_op, psw_in.c};
				op_ror: {res, flags.c} = {psw_in.c, dst_op};
				op_swab: res = {dst_op[7:0], dst_op[15:8]};
				default: res = dst_op;
			endcase
			// shifts and rotates
			if (opcode_sel inside {[op_ror:op_asl]})
				flags.v = res[word_width-1] ^ flags.c;
		end
		else if (inst_class == double_operand)
		begin
			write = !(opcode_sel[3:0] inside {{1'b0, op_cmp}, {1'b0, op_bit}});
			flags.v = 1'b0;
			case (opcode_sel[3:0])
				{1'b0, op_mov}: res = src_op;
				{1'b0, op_cmp}: {flags.v, flags.c, res} = add_vc(src_op, ~dst_op, 1'b1, 1'b1);
				{1'b0, op_bit}: res = src_op & dst_op;
				{1'b0, op_bic}: res = ~src_op & dst_op;
				{1'b0, op_bis}: res = src_op | dst_op;
				{1'b0, op_add}: {flags.v, flags.c, res} = add_vc(src_op, dst_op, 1'b0, 1'b0);
				{1'b1, op_sub}: {flags.v, flags.c, res} = add_vc(dst_op, ~src_op, 1'b1, 1'b1);
				default: res = dst_op;
			endcase
		end
		if (inst_class == single_operand || inst_class == double_operand)
		begin
			flags.n = low_byte ? res[7] : res[word_width-1];
			flags.z = low_byte ? (res[7:0] == 8'd0) : (res == '0);
		end
	end

	always_ff @(posedge clock or posedge reset)
	begin
		if (reset)
		begin
			wr_en <= 1'b0;
			branch_taken <= 1'b0;
		end
		else if (exec_en)
		begin
			wr_en <= write;
			branch_taken <= (inst_class == branch);
		end
	end

	always_ff @(posedge clock)
	begin
		if (exec_en)
		begin
			result <= res;
			new_psw <= flags;
		end
	end

endmodule

/* pdp_control.sv */
module pdp_control
	import pdp_pkg::*;
(
	input logic clock,
	input logic reset,
	input logic pc_at_end,
	output logic init_regs,
	output logic load_ir,
	output logic latch_ops,
	output logic exec_en,
	output logic commit,
	output logic done
);

	state_t state, next_state;

	always_ff @(posedge clock or posedge reset)
	begin
		if (reset)
			state <= sm_reset;
		else
			state <= next_state;
	end

	always_comb
	begin
		case (state)
			sm_reset: next_state = init_pc;
			init_pc: next_state = fetch;
			fetch: next_state = decode;
			decode: next_state = execute;
			execute: next_state = write_back;
			write_back: next_state = check_end;
			// pc already holds the next address here
			check_end: next_state = pc_at_end ? sm_done : fetch;
			sm_done: next_state = sm_done;
			default: next_state = sm_reset;
		endcase
	end

	// one strobe per state
	assign init_regs = (state == init_pc);
	assign load_ir = (state == fetch);
	assign latch_ops = (state == decode);
	assign exec_en = (state == execute);
	assign commit = (state == write_back);
	assign done = (state == sm_done);

endmodule

/* pdp_core.sv */
module pdp_core
	import pdp_pkg::*;
(
	input logic clock,
	input logic reset,
	input logic [addr_width-1:0] pc_start,
	input logic [addr_width-1:0] pc_end,
	output logic done,
	output logic wb_valid,
	output logic [reg_index_width-1:0] wb_reg,
	output logic [word_width-1:0] wb_data,
	output psw_t psw,
	output logic [addr_width-1:0] pc
);

	logic init_regs, load_ir, latch_ops, exec_en, commit, pc_at_end;
	logic wr_en, branch_taken;
	logic [addr_width-1:0] fetch_addr, branch_target;
	logic [word_width-1:0] inst_word, data_a, data_b, src_op, dst_op, result;
	logic [reg_index_width-1:0] rd_a, rd_b, dst_reg;
	logic [op_width-1:0] opcode_sel;
	inst_class_t inst_class;
	psw_t new_psw;

	// the memory read is registered, so the first fetch has to see pc_start
	// while the pc itself is still being loaded
	assign fetch_addr = init_regs ? pc_start : pc;

	pdp_control u_control (.*);
	pdp_memory u_memory (.addr(fetch_addr), .*);
	pdp_decode u_decode (.*);
	pdp_alu u_alu (.psw_in(psw), .*);
	pdp_regfile u_regfile (.wr_reg(dst_reg), .wr_data(result), .*);

	// write-back strobe once per instruction, flags included
	always_ff @(posedge clock or posedge reset)
	begin
		if (reset)
			wb_valid <= 1'b0;
		else
			wb_valid <= commit;
	end

	assign wb_reg = dst_reg;
	assign wb_data = result;

endmodule

/* pdp_decode.sv */
module pdp_decode
	import pdp_pkg::*;
(
	input logic clock,
	input logic reset,
	input logic load_ir,
	input logic latch_ops,
	input logic [word_width-1:0] inst_word,
	input logic [word_width-1:0] data_a,
	input logic [word_width-1:0] data_b,
	input logic [addr_width-1:0] pc,
	output logic [reg_index_width-1:0] rd_a,
	output logic [reg_index_width-1:0] rd_b,
	output inst_class_t inst_class,
	output logic [op_width-1:0] opcode_sel,
	output logic [word_width-1:0] src_op,
	output logic [word_width-1:0] dst_op,
	output logic [reg_index_width-1:0] dst_reg,
	output logic [addr_width-1:0] branch_target
);

	instruction_t ir;
	inst_class_t class_next;
	logic is_single, is_double, reg_modes;
	logic [op_width-1:0] sel_next;
	logic [word_width-1:0] offset_ext;

	always_ff @(posedge clock)
	begin
		if (load_ir)
			ir <= inst_word;
	end

	// register numbers sit in the same bits for both operand formats
	assign rd_a = ir.double_op.src_reg;
	assign rd_b = ir.double_op.dst_reg;

	// marker alone would also catch JSR and the 0064..0067 group
	assign is_single = (ir.single_op.opcode == op_swab)
		|| (!ir.single_op.opcode[op_width-1] && ir[14:11] == single_marker
		&& ir.single_op.opcode[4:0] inside {[op_clr[4:0]:op_asl[4:0]]});
	assign is_double = ir.double_op.byte_flag ? (ir.double_op.opcode == op_sub)
		: (ir.double_op.opcode inside {[op_mov:op_add]});
	assign reg_modes = (ir.double_op.src_mode == 3'd0) && (ir.double_op.dst_mode == 3'd0);

	always_comb
	begin
		if (ir.branch_op.opcode == op_br)
			class_next = branch;
		else if (is_single)
			class_next = (ir.single_op.mode == 3'd0) ? single_operand : unsupported;
		else if (is_double)
			class_next = reg_modes ? double_operand : unsupported;
		else
			class_next = unsupported;
	end

	// double ops select on {byte flag, opcode}
	assign sel_next = (class_next == single_operand) ? ir.single_op.opcode
		: op_width'({ir.double_op.byte_flag, ir.double_op.opcode});
	assign offset_ext = {{(word_width-9){ir.branch_op.offset[7]}}, ir.branch_op.offset, 1'b0};

	always_ff @(posedge clock or posedge reset)
	begin
		if (reset)
			inst_class <= unsupported;
		else if (latch_ops)
			inst_class <= class_next;
	end

	always_ff @(posedge clock)
	begin
		if (latch_ops)
		begin
			opcode_sel <= sel_next;
			src_op <= data_a;
			dst_op <= data_b;
			dst_reg <= ir.double_op.dst_reg;
			branch_target <= pc + 16'd2 + offset_ext;
		end
	end

endmodule

/* pdp_memory.sv */
module pdp_memory
	import pdp_pkg::*;
(
	input logic clock,
	input logic [addr_width-1:0] addr,
	output logic [word_width-1:0] inst_word
);

	logic [7:0] mem [mem_bytes];
	logic [mem_addr_width-1:0] byte_addr;

	initial
	begin
		$readmemh("program.mem", mem);
	end

	// only the low address bits reach the array
	assign byte_addr = addr[mem_addr_width-1:0];

	// big-endian word, wraps at the top of memory
	always_ff @(posedge clock)
	begin
		inst_word <= {mem[byte_addr], mem[byte_addr + 1'b1]};
	end

endmodule

/* pdp_pkg.sv */
package pdp_pkg;

	localparam int word_width = 16;
	localparam int addr_width = 16;
	localparam int mem_bytes = 256;
	localparam int mem_addr_width = $clog2(mem_bytes);
	localparam int reg_count = 8;
	localparam int reg_index_width = 3;
	localparam int op_width = 10;

	// R7 is the program counter
	localparam logic [reg_index_width-1:0] pc_index = reg_index_width'(reg_count - 1);

	// start values for R0..R5
	localparam logic [word_width-1:0] reg_init [reg_count-2] = '{
		16'o000014, 16'o000002, 16'o000004, 16'o000012, 16'o000010, 16'o000020
	};

	typedef enum logic [2:0] {
		sm_reset,
		init_pc,
		fetch,
		decode,
		execute,
		write_back,
		check_end,
		sm_done
	} state_t;

	typedef enum logic [1:0] {
		single_operand,
		double_operand,
		branch,
		unsupported
	} inst_class_t;

	// top bit of the 10-bit opcode is the byte flag
	typedef struct packed {
		logic [op_width-1:0] opcode;
		logic [2:0] mode;
		logic [reg_index_width-1:0] rn;
	} single_view_t;

	typedef struct packed {
		logic byte_flag;
		logic [2:0] opcode;
		logic [2:0] src_mode;
		logic [reg_index_width-1:0] src_reg;
		logic [2:0] dst_mode;
		logic [reg_index_width-1:0] dst_reg;
	} double_view_t;

	typedef struct packed {
		logic [7:0] opcode;
		logic [7:0] offset;
	} branch_view_t;

	typedef union packed {
		single_view_t single_op;
		double_view_t double_op;
		branch_view_t branch_op;
	} instruction_t;

	// single operand codes, bits 15..6
	localparam logic [op_width-1:0] op_swab = 10'o0003;
	localparam logic [op_width-1:0] op_clr = 10'o0050;
	localparam logic [op_width-1:0] op_com = 10'o0051;
	localparam logic [op_width-1:0] op_inc = 10'o0052;
	localparam logic [op_width-1:0] op_dec = 10'o0053;
	localparam logic [op_width-1:0] op_neg = 10'o0054;
	localparam logic [op_width-1:0] op_adc = 10'o0055;
	localparam logic [op_width-1:0] op_sbc = 10'o0056;
	localparam logic [op_width-1:0] op_tst = 10'o0057;
	localparam logic [op_width-1:0] op_ror = 10'o0060;
	localparam logic [op_width-1:0] op_rol = 10'o0061;
	localparam logic [op_width-1:0] op_asr = 10'o0062;
	localparam logic [op_width-1:0] op_asl = 10'o0063;

	// double operand codes, bits 14..12 with byte flag 0
	localparam logic [2:0] op_mov = 3'o1;
	localparam logic [2:0] op_cmp = 3'o2;
	localparam logic [2:0] op_bit = 3'o3;
	localparam logic [2:0] op_bic = 3'o4;
	localparam logic [2:0] op_bis = 3'o5;
	localparam logic [2:0] op_add = 3'o6;
	// SUB shares the ADD code but has the byte flag set
	localparam logic [2:0] op_sub = 3'o6;

	localparam logic [7:0] op_br = 8'h01;
	localparam logic [3:0] single_marker = 4'b0001;

	typedef struct packed {
		logic n;
		logic z;
		logic v;
		logic c;
	} psw_t;

endpackage

/* pdp_regfile.sv */
module pdp_regfile
	import pdp_pkg::*;
(
	input logic clock,
	input logic reset,
	input logic init_regs,
	input logic commit,
	input logic [addr_width-1:0] pc_start,
	input logic [addr_width-1:0] pc_end,
	input logic wr_en,
	input logic [reg_index_width-1:0] wr_reg,
	input logic [word_width-1:0] wr_data,
	input psw_t new_psw,
	input logic branch_taken,
	input logic [addr_width-1:0] branch_target,
	input logic [reg_index_width-1:0] rd_a,
	input logic [reg_index_width-1:0] rd_b,
	output logic [word_width-1:0] data_a,
	output logic [word_width-1:0] data_b,
	output logic [addr_width-1:0] pc,
	output psw_t psw,
	output logic pc_at_end
);

	// R0..R6, the pc is kept apart
	logic [word_width-1:0] regs [reg_count-1];

	always_ff @(posedge clock)
	begin
		if (init_regs)
		begin
			for (int i = 0; i < reg_count - 2; i++)
				regs[i] <= reg_init[i];
			regs[reg_count-2] <= '0;
		end
		else if (commit && wr_en && wr_reg != pc_index)
			regs[wr_reg] <= wr_data;
	end

	always_ff @(posedge clock or posedge reset)
	begin
		if (reset)
		begin
			pc <= '0;
			psw <= '0;
		end
		else if (init_regs)
		begin
			pc <= pc_start;
			psw <= '0;
		end
		else if (commit)
		begin
			psw <= new_psw;
			// a result written to R7 overrides the normal step
			if (wr_en && wr_reg == pc_index)
				pc <= wr_data;
			else if (branch_taken)
				pc <= branch_target;
			else
				pc <= pc + 16'd2;
		end
	end

	assign data_a = (rd_a == pc_index) ? pc : regs[rd_a];
	assign data_b = (rd_b == pc_index) ? pc : regs[rd_b];
	assign pc_at_end = (pc >= pc_end);

endmodule

/* pdp_sva.sv */
module pdp_sva
	import pdp_pkg::*;
(
	input logic clock,
	input logic reset,
	input logic done,
	input logic wb_valid,
	input logic load_ir,
	input logic [addr_width-1:0] pc,
	input logic [addr_width-1:0] pc_end
);

	timeunit 1ns;
	timeprecision 100ps;

	int failures = 0;

	quiet_in_reset: assert property (@(posedge clock) reset |-> !wb_valid && !done)
	else
	begin
		failures++;
		$error("wb_valid or done high while reset is held");
	end

	// first instruction retires 6 cycles after reset release
	first_write_back: assert property (@(posedge clock)
		$fell(reset) |-> !wb_valid [*6] ##1 wb_valid)
	else
	begin
		failures++;
		$error("first write-back not 6 cycles after reset release");
	end

	write_back_after_fetch: assert property (@(posedge clock) disable iff (reset)
		wb_valid |-> $past(load_ir, 4) && !$past(wb_valid))
	else
	begin
		failures++;
		$error("write-back strobe not 4 cycles after its fetch");
	end

	// one instruction every 5 cycles until the end of code
	instruction_period: assert property (@(posedge clock) disable iff (reset)
		wb_valid |=> !wb_valid [*4] ##1 (wb_valid || done))
	else
	begin
		failures++;
		$error("write-back strobes are not 5 cycles apart");
	end

	done_holds: assert property (@(posedge clock) disable iff (reset)
		done |=> done && !wb_valid)
	else
	begin
		failures++;
		$error("done dropped or a write-back followed it");
	end

	done_at_end: assert property (@(posedge clock) disable iff (reset)
		done |-> pc >= pc_end)
	else
	begin
		failures++;
		$error("done high with pc below pc_end");
	end

endmodule

bind pdp_core pdp_sva u_sva (
	.clock,
	.reset,
	.done,
	.wb_valid,
	.load_ir,
	.pc,
	.pc_end
);

/* program.mem */
// big-endian words, two instructions per line, each as high byte then low byte
// the first line is address 0 and each line covers four bytes
10 42 e0 40 // 00: MOV R1,R2    SUB R1,R0
20 43 0b 44 // 04: CMP R1,R3    ADC R4
0b 01 0b 85 // 08: NEG R1       SBC R5
60 45 0c 02 // 12: ADD R1,R5    ROR R2
0c 42 0c 81 // 16: ROL R2       ASR R1
0c c4 00 c4 // 20: ASL R4       SWAB R4
0a 40 0a 80 // 24: COM R0       INC R0
30 c0 40 c0 // 28: BIT R3,R0    BIC R3,R0
51 43 0b c2 // 32: BIS R5,R3    TST R2
01 01 0a 03 // 36: BR 40        CLR R3 (skipped)
0a c2 0a 05 // 40: DEC R2       CLR R5
0a c5 0c 05 // 44: DEC R5       ROR R5
0a 85 0b 05 // 48: INC R5       NEG R5
0b 85 61 45 // 52: SBC R5       ADD R5,R5
e0 45 01 02 // 56: SUB R1,R5    BR 64
0a 40 0a 81 // 60: COM R0       INC R1 (both skipped)
0b 42 10 01 // 64: ADC R2       MOV R0,R1

/* tb_pdp.sv */
module tb_pdp
	import pdp_pkg::*;
();

	timeunit 1ns;
	timeprecision 100ps;

	logic clock;
	logic reset;
	logic [addr_width-1:0] pc_start;
	logic [addr_width-1:0] pc_end;
	logic done;
	logic wb_valid;
	logic [reg_index_width-1:0] wb_reg;
	logic [word_width-1:0] wb_data;
	psw_t psw;
	logic [addr_width-1:0] pc;

	// reference model state
	logic [7:0] image [mem_bytes];
	logic [15:0] regs_m [8];
	logic [15:0] pc_m;
	logic n_m, z_m, v_m, c_m;
	logic exp_write;
	logic [2:0] exp_reg;
	logic [15:0] exp_data;
	int mismatches = 0;
	int timeouts = 0;

	pdp_core uut (.*);

	initial
	begin
		clock = 1'b0;
		forever #20 clock = ~clock;
	end

	task automatic note_mismatch(input string msg);
		$display("mismatch at %0d ns: %s", $time, msg);
		mismatches++;
	endtask

	task automatic init_model();
		regs_m[0] = 16'o000014;
		regs_m[1] = 16'o000002;
		regs_m[2] = 16'o000004;
		regs_m[3] = 16'o000012;
		regs_m[4] = 16'o000010;
		regs_m[5] = 16'o000020;
		regs_m[6] = 16'd0;
		regs_m[7] = 16'd0;
		pc_m = pc_start;
		{n_m, z_m, v_m, c_m} = 4'b0000;
	endtask

	// runs one instruction at pc_m and leaves the expected write-back behind
	task automatic step_model();
		logic [15:0] inst, s, d, r;
		logic [16:0] sum;
		logic [9:0] op;
		logic [3:0] op2;
		logic [7:0] lo_addr;
		logic single, double, v_new, c_new;
		lo_addr = pc_m[7:0] + 8'd1;
		inst = {image[pc_m[7:0]], image[lo_addr]};
		op = inst[15:6];
		op2 = inst[15:12];
		s = regs_m[inst[8:6]];
		d = regs_m[inst[2:0]];
		r = d;
		v_new = v_m;
		c_new = c_m;
		single = (op == 10'o0003) || (op >= 10'o0050 && op <= 10'o0063);
		double = (op2 >= 4'd1 && op2 <= 4'd6) || op2 == 4'he;
		exp_write = 1'b0;
		exp_reg = inst[2:0];
		if (single)
		begin
			// TST is the only single-operand op that keeps the register
			exp_write = (op != 10'o0057);
			case (op)
				10'o0050: r = 16'd0;
				10'o0051: r = ~d;
				10'o0052: r = d + 16'd1;
				10'o0053: r = d - 16'd1;
				10'o0054: r = 16'd0 - d;
				10'o0055: r = d + {15'd0, c_m};
				10'o0056: r = d - {15'd0, c_m};
				10'o0060: r = {c_m, d[15:1]};
				10'o0061: r = {d[14:0], c_m};
				10'o0062: r = {d[15], d[15:1]};
				10'o0063: r = {d[14:0], 1'b0};
				10'o0003: r = {d[7:0], d[15:8]};
				default: r = d;
			endcase
			case (op)
				10'o0051: c_new = 1'b1;
				10'o0052, 10'o0053: c_new = c_m;
				10'o0054: c_new = (r != 16'd0);
				10'o0055: c_new = c_m && (d == 16'hffff);
				10'o0056: c_new = c_m && (d == 16'h0000);
				10'o0060, 10'o0062: c_new = d[0];
				10'o0061, 10'o0063: c_new = d[15];
				default: c_new = 1'b0;
			endcase
			case (op)
				10'o0052, 10'o0054: v_new = (r == 16'h8000);
				10'o0053: v_new = (r == 16'h7fff);
				10'o0055: v_new = c_m && (d == 16'h7fff);
				10'o0056: v_new = c_m && (d == 16'h8000);
				10'o0060, 10'o0061, 10'o0062, 10'o0063: v_new = r[15] ^ c_new;
				default: v_new = 1'b0;
			endcase
		end
		else if (double)
		begin
			// CMP and BIT only set flags
			exp_write = !(op2 == 4'd2 || op2 == 4'd3);
			v_new = 1'b0;
			case (op2)
				4'd1: r = s;
				4'd2: r = s - d;
				4'd3: r = s & d;
				4'd4: r = d & ~s;
				4'd5: r = d | s;
				4'd6: r = d + s;
				default: r = d - s;
			endcase
			if (op2 == 4'd6)
			begin
				sum = {1'b0, d} + {1'b0, s};
				c_new = sum[16];
				v_new = (s[15] == d[15]) && (r[15] != d[15]);
			end
			else if (op2 == 4'd2)
			begin
				c_new = (d > s);
				v_new = (s[15] != d[15]) && (r[15] != s[15]);
			end
			else if (op2 == 4'he)
			begin
				c_new = (s > d);
				v_new = (d[15] != s[15]) && (r[15] != d[15]);
			end
		end
		if (single || double)
		begin
			n_m = (op == 10'o0003) ? r[7] : r[15];
			z_m = (op == 10'o0003) ? (r[7:0] == 8'd0) : (r == 16'd0);
			v_m = v_new;
			c_m = c_new;
		end
		exp_data = r;
		if (exp_write)
			regs_m[inst[2:0]] = r;
		// BR offset counts words from the next instruction
		if (inst[15:8] == 8'h01)
			pc_m = pc_m + 16'd2 + {{7{inst[7]}}, inst[7:0], 1'b0};
		else if (exp_write && inst[2:0] == 3'd7)
			pc_m = r;
		else
			pc_m = pc_m + 16'd2;
	endtask

	// flags and pc are already updated while wb_valid is high
	task automatic wait_for_write_back(input int limit, output bit ok);
		ok = 1'b0;
		for (int i = 0; i < limit && !ok; i++)
		begin
			@(negedge clock);
			ok = wb_valid;
		end
		if (!ok)
		begin
			$display("timeout: no write-back within %0d cycles", limit);
			timeouts++;
		end
	endtask

	task automatic check_step();
		if (exp_write)
		begin
			assert (wb_reg == exp_reg)
			else note_mismatch($sformatf("wb_reg %0d, expected %0d", wb_reg, exp_reg));
			assert (wb_data == exp_data)
			else note_mismatch($sformatf("wb_data %o, expected %o", wb_data, exp_data));
		end
		assert ({psw.n, psw.z, psw.v, psw.c} == {n_m, z_m, v_m, c_m})
		else note_mismatch($sformatf("nzvc %b%b%b%b, expected %b%b%b%b",
			psw.n, psw.z, psw.v, psw.c, n_m, z_m, v_m, c_m));
		assert (pc == pc_m)
		else note_mismatch($sformatf("pc %0d, expected %0d", pc, pc_m));
		assert (!done)
		else note_mismatch("done high before the end of code");
	endtask

	task automatic wait_for_done(input int limit, output bit ok);
		ok = 1'b0;
		for (int i = 0; i < limit && !ok; i++)
		begin
			@(negedge clock);
			ok = done;
		end
		if (!ok)
		begin
			$display("timeout: done did not rise within %0d cycles", limit);
			timeouts++;
		end
	endtask

	task automatic check_hold(input int cycles);
		for (int i = 0; i < cycles; i++)
		begin
			@(negedge clock);
			assert (done)
			else note_mismatch("done dropped after the end of code");
			assert (!wb_valid)
			else note_mismatch("write-back after done");
		end
	endtask

	initial
	begin
		bit ok;
		reset = 1'b1;
		pc_start = 16'd0;
		pc_end = 16'd68;
		ok = 1'b1;
		$readmemh("program.mem", image);
		init_model();
		repeat (8)
			@(posedge clock);
		#2;
		reset = 1'b0;
		while (ok && pc_m < pc_end)
		begin
			step_model();
			wait_for_write_back(12, ok);
			if (ok)
				check_step();
		end
		if (ok)
			wait_for_done(8, ok);
		if (ok)
			check_hold(20);
		$display("errors: %0d mismatches, %0d timeouts, %0d assertion failures",
			mismatches, timeouts, uut.u_sva.failures);
		if (mismatches == 0 && timeouts == 0 && uut.u_sva.failures == 0)
			$display("*** TEST PASSED ***");
		else
			$display("*** TEST FAILED ***");
		$finish;
	end

endmodule
